/* hdl/decode_pkg.sv */
package decode_pkg;

  localparam int default_xlen = 32;

  typedef logic [4:0]  reg_idx_t;
  typedef logic [31:0] inst_t;

  // internal operations, zero must stay invalid so a cleared latch is a bubble
  typedef enum logic [5:0] {
    op_invalid = 6'd0,
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_slt,
    op_sltu,
    op_sra,
    op_srl,
    op_sll,
    op_mul,
    op_addi,
    op_andi,
    op_ori,
    op_xori,
    op_slti,
    op_sltiu,
    op_srai,
    op_srli,
    op_slli,
    op_lui,
    op_auipc,
    op_lw,
    op_sw,
    op_jal,
    op_jalr,
    op_beq,
    op_bne,
    op_blt,
    op_bge,
    op_bltu,
    op_bgeu
  } iop_t;

  typedef enum logic [1:0] {
    type_i = 2'd0,
    type_r,
    type_s,   // stores and branches
    type_u    // jal only
  } inst_type_t;

  typedef enum logic [2:0] {imm_i, imm_s, imm_b, imm_u, imm_j} imm_type_t;

  // major opcodes, inst[6:0]
  localparam logic [6:0] opcode_op     = 7'b0110011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;
  localparam logic [6:0] opcode_lui    = 7'b0110111;
  localparam logic [6:0] opcode_auipc  = 7'b0010111;
  localparam logic [6:0] opcode_load   = 7'b0000011;
  localparam logic [6:0] opcode_store  = 7'b0100011;
  localparam logic [6:0] opcode_jal    = 7'b1101111;
  localparam logic [6:0] opcode_jalr   = 7'b1100111;
  localparam logic [6:0] opcode_branch = 7'b1100011;

  localparam logic [6:0] funct7_base   = 7'b0000000;
  localparam logic [6:0] funct7_alt    = 7'b0100000;  // sub, sra, srai
  localparam logic [6:0] funct7_muldiv = 7'b0000001;

endpackage

/* hdl/inst_decoder.sv */
module inst_decoder (
  input  logic [6:0]             opcode,
  input  logic [2:0]             funct3,
  input  logic [6:0]             funct7,
  output decode_pkg::iop_t       op,
  output decode_pkg::inst_type_t inst_type,
  output decode_pkg::imm_type_t  imm_type,
  output logic                   rs1_used,
  output logic                   rs2_used,
  output logic                   wr_reg
);

  // opcode / funct3 / funct7 to internal operation
  always_comb begin
    op = decode_pkg::op_invalid;
    case (opcode)
      decode_pkg::opcode_op: begin
        if (funct7 == decode_pkg::funct7_base) begin
          case (funct3)
            3'd0: op = decode_pkg::op_add;
            3'd1: op = decode_pkg::op_sll;
            3'd2: op = decode_pkg::op_slt;
            3'd3: op = decode_pkg::op_sltu;
            3'd4: op = decode_pkg::op_xor;
            3'd5: op = decode_pkg::op_srl;
            3'd6: op = decode_pkg::op_or;
            default: op = decode_pkg::op_and;
          endcase
        end else if (funct7 == decode_pkg::funct7_alt) begin
          if (funct3 == 3'd0) op = decode_pkg::op_sub;
          else if (funct3 == 3'd5) op = decode_pkg::op_sra;
        end else if (funct7 == decode_pkg::funct7_muldiv && funct3 == 3'd0) begin
          op = decode_pkg::op_mul;  // only mul of the M extension
        end
      end
      decode_pkg::opcode_op_imm: begin
        case (funct3)
          3'd0: op = decode_pkg::op_addi;
          3'd2: op = decode_pkg::op_slti;
          3'd3: op = decode_pkg::op_sltiu;
          3'd4: op = decode_pkg::op_xori;
          3'd6: op = decode_pkg::op_ori;
          3'd7: op = decode_pkg::op_andi;
          3'd1: if (funct7 == decode_pkg::funct7_base) op = decode_pkg::op_slli;
          default: begin  // funct3 5, shift right
            if (funct7 == decode_pkg::funct7_base) op = decode_pkg::op_srli;
            else if (funct7 == decode_pkg::funct7_alt) op = decode_pkg::op_srai;
          end
        endcase
      end
      decode_pkg::opcode_lui:   op = decode_pkg::op_lui;
      decode_pkg::opcode_auipc: op = decode_pkg::op_auipc;
      decode_pkg::opcode_jal:   op = decode_pkg::op_jal;
      decode_pkg::opcode_load:  if (funct3 == 3'd0) op = decode_pkg::op_lw;
      decode_pkg::opcode_store: if (funct3 == 3'd0) op = decode_pkg::op_sw;
      decode_pkg::opcode_jalr:  if (funct3 == 3'd0) op = decode_pkg::op_jalr;
      decode_pkg::opcode_branch: begin
        case (funct3)
          3'd0: op = decode_pkg::op_beq;
          3'd1: op = decode_pkg::op_bne;
          3'd4: op = decode_pkg::op_blt;
          3'd5: op = decode_pkg::op_bge;
          3'd6: op = decode_pkg::op_bltu;
          3'd7: op = decode_pkg::op_bgeu;
          default: op = decode_pkg::op_invalid;
        endcase
      end
      default: op = decode_pkg::op_invalid;
    endcase
  end

  // format and immediate kind follow from the operation
  always_comb begin
    inst_type = decode_pkg::type_i;
    imm_type  = decode_pkg::imm_i;
    case (op)
      decode_pkg::op_add, decode_pkg::op_sub, decode_pkg::op_and, decode_pkg::op_or,
      decode_pkg::op_xor, decode_pkg::op_slt, decode_pkg::op_sltu, decode_pkg::op_sra,
      decode_pkg::op_srl, decode_pkg::op_sll, decode_pkg::op_mul:
        inst_type = decode_pkg::type_r;
      decode_pkg::op_sw: begin
        inst_type = decode_pkg::type_s;
        imm_type  = decode_pkg::imm_s;
      end
      decode_pkg::op_beq, decode_pkg::op_bne, decode_pkg::op_blt,
      decode_pkg::op_bge, decode_pkg::op_bltu, decode_pkg::op_bgeu: begin
        inst_type = decode_pkg::type_s;
        imm_type  = decode_pkg::imm_b;
      end
      decode_pkg::op_jal: begin
        inst_type = decode_pkg::type_u;
        imm_type  = decode_pkg::imm_j;
      end
      decode_pkg::op_lui, decode_pkg::op_auipc: imm_type = decode_pkg::imm_u;
      default: ;
    endcase
  end

  // lui, auipc and jal are the only valid ops with imm_u / imm_j
  assign rs1_used = (op != decode_pkg::op_invalid) &&
                    (imm_type != decode_pkg::imm_u) && (imm_type != decode_pkg::imm_j);
  assign rs2_used = (inst_type == decode_pkg::type_r) || (inst_type == decode_pkg::type_s);
  assign wr_reg   = (op != decode_pkg::op_invalid) && (inst_type != decode_pkg::type_s);

endmodule

/* hdl/imm_gen.sv */
module imm_gen #(
  parameter int xlen = 32
) (
  input  decode_pkg::inst_t     inst,
  input  decode_pkg::imm_type_t imm_type,
  output logic [xlen-1:0]       imm
);

  logic [31:0] imm32;  // raw 32-bit immediate before widening

  always_comb begin
    case (imm_type)
      decode_pkg::imm_i:
        imm32 = {{21{inst[31]}}, inst[30:20]};
      decode_pkg::imm_s:
        imm32 = {{21{inst[31]}}, inst[30:25], inst[11:7]};
      decode_pkg::imm_b:  // byte offset, bit 0 always zero
        imm32 = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      decode_pkg::imm_u:
        imm32 = {inst[31:12], 12'b0};
      decode_pkg::imm_j:
        imm32 = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      default:
        imm32 = '0;
    endcase
  end

  // sign bit is inst[31] in every layout
  assign imm = xlen'(signed'(imm32));

endmodule

/* hdl/reg_file.sv */
module reg_file #(
  parameter int xlen = 32
) (
  input  logic                 clk,
  input  logic                 reset,
  input  decode_pkg::reg_idx_t raddr1,
  input  decode_pkg::reg_idx_t raddr2,
  output logic [xlen-1:0]      rdata1,
  output logic [xlen-1:0]      rdata2,
  input  logic                 wr_en,
  input  decode_pkg::reg_idx_t waddr,
  input  logic [xlen-1:0]      wdata
);

  logic [xlen-1:0] regs [32];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && waddr != '0) begin  // x0 is hardwired
      regs[waddr] <= wdata;
    end
  end

  // combinational reads, a same-cycle write shows up next cycle
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* hdl/hazard_unit.sv */
module hazard_unit (
  input  decode_pkg::reg_idx_t rs1,
  input  decode_pkg::reg_idx_t rs2,
  input  logic                 rs1_used,
  input  logic                 rs2_used,
  input  decode_pkg::reg_idx_t agex_rd,
  input  decode_pkg::reg_idx_t mem_rd,
  input  decode_pkg::reg_idx_t wb_rd,
  input  logic                 agex_wr_reg,
  input  logic                 mem_wr_reg,
  input  logic                 wb_wr_reg,
  output logic                 stall
);

  logic rs1_pending;
  logic rs2_pending;

  // true when a later stage still has to write src
  function automatic logic pending(input decode_pkg::reg_idx_t src);
    logic hit;
    hit = (agex_wr_reg && agex_rd == src) ||
          (mem_wr_reg  && mem_rd  == src) ||
          (wb_wr_reg   && wb_rd   == src);
    return hit && (src != '0);  // x0 never waits
  endfunction

  assign rs1_pending = rs1_used && pending(rs1);
  assign rs2_pending = rs2_used && pending(rs2);

  assign stall = rs1_pending || rs2_pending;

endmodule

/* hdl/decode_stage.sv */
module decode_stage #(
  parameter int xlen = decode_pkg::default_xlen
) (
  input  logic                   clk,
  input  logic                   reset,
  input  decode_pkg::inst_t      fe_inst,
  input  logic [xlen-1:0]        fe_pc,
  input  logic [xlen-1:0]        fe_pcplus,
  input  decode_pkg::reg_idx_t   agex_rd,
  input  logic                   agex_wr_reg,
  input  decode_pkg::reg_idx_t   mem_rd,
  input  logic                   mem_wr_reg,
  input  decode_pkg::reg_idx_t   wb_rd,
  input  logic                   wb_wr_reg,     // also the register file write strobe
  input  logic [xlen-1:0]        wb_data,
  input  logic                   agex_br_taken,
  output logic                   stall,         // to fetch
  output decode_pkg::inst_t      de_inst,
  output logic [xlen-1:0]        de_pc,
  output logic [xlen-1:0]        de_pcplus,
  output decode_pkg::iop_t       de_op,
  output decode_pkg::inst_type_t de_type,
  output logic [xlen-1:0]        de_regval1,
  output logic [xlen-1:0]        de_regval2,
  output logic [xlen-1:0]        de_imm,
  output decode_pkg::reg_idx_t   de_rd,
  output logic                   de_wr_reg
);

  logic [6:0]             opcode;
  logic [2:0]             funct3;
  logic [6:0]             funct7;
  decode_pkg::reg_idx_t   rs1;
  decode_pkg::reg_idx_t   rs2;
  decode_pkg::reg_idx_t   rd;
  decode_pkg::iop_t       op;
  decode_pkg::inst_type_t inst_type;
  decode_pkg::imm_type_t  imm_type;
  logic                   rs1_used;
  logic                   rs2_used;
  logic                   wr_reg;
  logic [xlen-1:0]        regval1;
  logic [xlen-1:0]        regval2;
  logic [xlen-1:0]        imm;
  logic                   bubble;

  // instruction fields
  assign opcode = fe_inst[6:0];
  assign rd     = fe_inst[11:7];
  assign funct3 = fe_inst[14:12];
  assign rs1    = fe_inst[19:15];
  assign rs2    = fe_inst[24:20];
  assign funct7 = fe_inst[31:25];

  inst_decoder u_decoder (
    .opcode   (opcode),
    .funct3   (funct3),
    .funct7   (funct7),
    .op       (op),
    .inst_type(inst_type),
    .imm_type (imm_type),
    .rs1_used (rs1_used),
    .rs2_used (rs2_used),
    .wr_reg   (wr_reg)
  );

  imm_gen #(.xlen(xlen)) u_imm (
    .inst    (fe_inst),
    .imm_type(imm_type),
    .imm     (imm)
  );

  reg_file #(.xlen(xlen)) u_regs (
    .clk   (clk),
    .reset (reset),
    .raddr1(rs1),
    .raddr2(rs2),
    .rdata1(regval1),
    .rdata2(regval2),
    .wr_en (wb_wr_reg),
    .waddr (wb_rd),
    .wdata (wb_data)
  );

  hazard_unit u_hazard (
    .rs1        (rs1),
    .rs2        (rs2),
    .rs1_used   (rs1_used),
    .rs2_used   (rs2_used),
    .agex_rd    (agex_rd),
    .mem_rd     (mem_rd),
    .wb_rd      (wb_rd),
    .agex_wr_reg(agex_wr_reg),
    .mem_wr_reg (mem_wr_reg),
    .wb_wr_reg  (wb_wr_reg),
    .stall      (stall)
  );

  // stalled, flushed or empty slot goes down the pipe as all zeros
  assign bubble = stall || agex_br_taken || (fe_inst == '0);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      de_inst    <= '0;
      de_pc      <= '0;
      de_pcplus  <= '0;
      de_op      <= decode_pkg::op_invalid;
      de_type    <= decode_pkg::type_i;
      de_regval1 <= '0;
      de_regval2 <= '0;
      de_imm     <= '0;
      de_rd      <= '0;
      de_wr_reg  <= 1'b0;
    end else if (bubble) begin
      de_inst    <= '0;
      de_pc      <= '0;
      de_pcplus  <= '0;
      de_op      <= decode_pkg::op_invalid;
      de_type    <= decode_pkg::type_i;
      de_regval1 <= '0;
      de_regval2 <= '0;
      de_imm     <= '0;
      de_rd      <= '0;
      de_wr_reg  <= 1'b0;
    end else begin
      de_inst    <= fe_inst;
      de_pc      <= fe_pc;
      de_pcplus  <= fe_pcplus;
      de_op      <= op;
      de_type    <= inst_type;
      de_regval1 <= regval1;
      de_regval2 <= regval2;
      de_imm     <= imm;
      de_rd      <= rd;
      de_wr_reg  <= wr_reg;
    end
  end

endmodule

/* sim/decode_stage_tb.sv */
module decode_stage_tb;

  localparam int xlen       = decode_pkg::default_xlen;
  localparam int max_cycles = 2000;
  // hazard word {agex_rd, agex_w, mem_rd, mem_w, wb_rd, wb_w}, rd kept in 0..3
  localparam logic [17:0] near_mask = 18'b00011_1_00011_1_00011_1;

  typedef struct packed {
    decode_pkg::inst_t      inst;
    logic [xlen-1:0]        pc;
    logic [xlen-1:0]        pcplus;
    decode_pkg::iop_t       op;
    decode_pkg::inst_type_t typ;
    logic [xlen-1:0]        regval1;
    logic [xlen-1:0]        regval2;
    logic [xlen-1:0]        imm;
    decode_pkg::reg_idx_t   rd;
    logic                   wr_reg;
  } latch_t;

  logic                   clk;
  logic                   reset;
  decode_pkg::inst_t      fe_inst;
  logic [xlen-1:0]        fe_pc;
  logic [xlen-1:0]        fe_pcplus;
  decode_pkg::reg_idx_t   agex_rd;
  logic                   agex_wr_reg;
  decode_pkg::reg_idx_t   mem_rd;
  logic                   mem_wr_reg;
  decode_pkg::reg_idx_t   wb_rd;
  logic                   wb_wr_reg;
  logic [xlen-1:0]        wb_data;
  logic                   agex_br_taken;
  logic                   stall;
  decode_pkg::inst_t      de_inst;
  logic [xlen-1:0]        de_pc;
  logic [xlen-1:0]        de_pcplus;
  decode_pkg::iop_t       de_op;
  decode_pkg::inst_type_t de_type;
  logic [xlen-1:0]        de_regval1;
  logic [xlen-1:0]        de_regval2;
  logic [xlen-1:0]        de_imm;
  decode_pkg::reg_idx_t   de_rd;
  logic                   de_wr_reg;

  latch_t          exp_next;  // what the latch should take at the coming edge
  latch_t          exp_q;     // what the latch should hold now
  latch_t          de_all;
  logic            exp_stall;
  logic [xlen-1:0] ref_regs [32];
  int              cycles;

  logic [6:0] opcodes [9] = '{decode_pkg::opcode_op, decode_pkg::opcode_op_imm,
    decode_pkg::opcode_lui, decode_pkg::opcode_auipc, decode_pkg::opcode_load,
    decode_pkg::opcode_store, decode_pkg::opcode_jal, decode_pkg::opcode_jalr,
    decode_pkg::opcode_branch};
  logic [6:0] f7s [3] = '{decode_pkg::funct7_base, decode_pkg::funct7_alt,
    decode_pkg::funct7_muldiv};
  // indexed by funct3
  decode_pkg::iop_t r_ops [8] = '{decode_pkg::op_add, decode_pkg::op_sll, decode_pkg::op_slt,
    decode_pkg::op_sltu, decode_pkg::op_xor, decode_pkg::op_srl, decode_pkg::op_or,
    decode_pkg::op_and};
  decode_pkg::iop_t i_ops [8] = '{decode_pkg::op_addi, decode_pkg::op_slli,
    decode_pkg::op_slti, decode_pkg::op_sltiu, decode_pkg::op_xori, decode_pkg::op_srli,
    decode_pkg::op_ori, decode_pkg::op_andi};
  decode_pkg::iop_t b_ops [8] = '{decode_pkg::op_beq, decode_pkg::op_bne,
    decode_pkg::op_invalid, decode_pkg::op_invalid, decode_pkg::op_blt, decode_pkg::op_bge,
    decode_pkg::op_bltu, decode_pkg::op_bgeu};

  decode_stage #(.xlen(xlen)) i_dut (
    .clk(clk), .reset(reset), .fe_inst(fe_inst), .fe_pc(fe_pc), .fe_pcplus(fe_pcplus),
    .agex_rd(agex_rd), .agex_wr_reg(agex_wr_reg), .mem_rd(mem_rd), .mem_wr_reg(mem_wr_reg),
    .wb_rd(wb_rd), .wb_wr_reg(wb_wr_reg), .wb_data(wb_data), .agex_br_taken(agex_br_taken),
    .stall(stall), .de_inst(de_inst), .de_pc(de_pc), .de_pcplus(de_pcplus), .de_op(de_op),
    .de_type(de_type), .de_regval1(de_regval1), .de_regval2(de_regval2), .de_imm(de_imm),
    .de_rd(de_rd), .de_wr_reg(de_wr_reg)
  );

  assign de_all = {de_inst, de_pc, de_pcplus, de_op, de_type, de_regval1, de_regval2,
                   de_imm, de_rd, de_wr_reg};

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk or posedge reset) begin
    if (reset) exp_q <= '0;
    else exp_q <= exp_next;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= max_cycles) begin
      $display("Timeout: the run did not finish within %0d clock cycles", max_cycles);
      $display("TEST FAILED");
      $fatal(1, "timeout");
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("Error at %0t: %s expected %h actual %h", $time, name, exp, act);
    $display("TEST FAILED");
    $fatal(1, "mismatch on %s", name);
  endtask

  // first field that differs gets reported
  task automatic show_latch_diff(input latch_t e, input latch_t a);
    if (e.inst !== a.inst) report_mismatch("de_inst", e.inst, a.inst);
    else if (e.pc !== a.pc) report_mismatch("de_pc", e.pc, a.pc);
    else if (e.pcplus !== a.pcplus) report_mismatch("de_pcplus", e.pcplus, a.pcplus);
    else if (e.op !== a.op) report_mismatch("de_op", 32'(e.op), 32'(a.op));
    else if (e.typ !== a.typ) report_mismatch("de_type", 32'(e.typ), 32'(a.typ));
    else if (e.regval1 !== a.regval1) report_mismatch("de_regval1", e.regval1, a.regval1);
    else if (e.regval2 !== a.regval2) report_mismatch("de_regval2", e.regval2, a.regval2);
    else if (e.imm !== a.imm) report_mismatch("de_imm", e.imm, a.imm);
    else if (e.rd !== a.rd) report_mismatch("de_rd", 32'(e.rd), 32'(a.rd));
    else report_mismatch("de_wr_reg", 32'(e.wr_reg), 32'(a.wr_reg));
  endtask

  latch_check: assert property (@(posedge clk) disable iff (reset) de_all === exp_q)
    else show_latch_diff($sampled(exp_q), $sampled(de_all));
  stall_check: assert property (@(posedge clk) disable iff (reset) stall === exp_stall)
    else report_mismatch("stall", 32'($sampled(exp_stall)), 32'($sampled(stall)));
  stall_bubble: assert property (@(posedge clk) disable iff (reset) stall |=> de_all == '0)
    else show_latch_diff('0, $sampled(de_all));
  flush_bubble: assert property (@(posedge clk) disable iff (reset)
      (agex_br_taken || fe_inst == '0) |=> de_all == '0)
    else show_latch_diff('0, $sampled(de_all));
  lui_no_stall: assert property (@(posedge clk) disable iff (reset)
      (fe_inst[6:0] == decode_pkg::opcode_lui) |-> !stall)
    else report_mismatch("stall", 32'(0), 32'(1));
  quiet_no_stall: assert property (@(posedge clk) disable iff (reset)
      !(agex_wr_reg || mem_wr_reg || wb_wr_reg) |-> !stall)
    else report_mismatch("stall", 32'(0), 32'(1));

  function automatic decode_pkg::iop_t lookup_op(input decode_pkg::inst_t inst);
    logic [6:0]       opc;
    logic [2:0]       f3;
    logic [6:0]       f7;
    decode_pkg::iop_t op;
    opc = inst[6:0];
    f3  = inst[14:12];
    f7  = inst[31:25];
    op  = decode_pkg::op_invalid;
    case (opc)
      decode_pkg::opcode_op: begin
        if (f7 == decode_pkg::funct7_base) op = r_ops[f3];
        else if (f7 == decode_pkg::funct7_alt && f3 == 3'd0) op = decode_pkg::op_sub;
        else if (f7 == decode_pkg::funct7_alt && f3 == 3'd5) op = decode_pkg::op_sra;
        else if (f7 == decode_pkg::funct7_muldiv && f3 == 3'd0) op = decode_pkg::op_mul;
      end
      decode_pkg::opcode_op_imm: begin
        if (f3 != 3'd1 && f3 != 3'd5) op = i_ops[f3];  // only shifts look at funct7
        else if (f7 == decode_pkg::funct7_base) op = i_ops[f3];
        else if (f7 == decode_pkg::funct7_alt && f3 == 3'd5) op = decode_pkg::op_srai;
      end
      decode_pkg::opcode_lui:    op = decode_pkg::op_lui;
      decode_pkg::opcode_auipc:  op = decode_pkg::op_auipc;
      decode_pkg::opcode_jal:    op = decode_pkg::op_jal;
      decode_pkg::opcode_load:   if (f3 == 3'd0) op = decode_pkg::op_lw;
      decode_pkg::opcode_store:  if (f3 == 3'd0) op = decode_pkg::op_sw;
      decode_pkg::opcode_jalr:   if (f3 == 3'd0) op = decode_pkg::op_jalr;
      decode_pkg::opcode_branch: op = b_ops[f3];
      default: ;
    endcase
    return op;
  endfunction

  task automatic classify(input decode_pkg::iop_t op, output decode_pkg::inst_type_t t,
                          output decode_pkg::imm_type_t k);
    t = decode_pkg::type_i;
    k = decode_pkg::imm_i;
    if (op inside {[decode_pkg::op_add:decode_pkg::op_mul]}) begin
      t = decode_pkg::type_r;
    end else if (op == decode_pkg::op_sw) begin
      t = decode_pkg::type_s;
      k = decode_pkg::imm_s;
    end else if (op inside {[decode_pkg::op_beq:decode_pkg::op_bgeu]}) begin
      t = decode_pkg::type_s;
      k = decode_pkg::imm_b;
    end else if (op == decode_pkg::op_jal) begin
      t = decode_pkg::type_u;
      k = decode_pkg::imm_j;
    end else if (op == decode_pkg::op_lui || op == decode_pkg::op_auipc) begin
      k = decode_pkg::imm_u;
    end
  endtask

  function automatic logic [31:0] sign_extend(input logic [31:0] v, input int w);
    logic signed [31:0] s;
    s = $signed(v << (32 - w));
    return s >>> (32 - w);
  endfunction

  // standard RV32I immediate layouts
  function automatic logic [31:0] layout_imm(input decode_pkg::inst_t inst,
                                             input decode_pkg::imm_type_t k);
    case (k)
      decode_pkg::imm_i: return sign_extend(32'(inst[31:20]), 12);
      decode_pkg::imm_s: return sign_extend(32'({inst[31:25], inst[11:7]}), 12);
      decode_pkg::imm_b:
        return sign_extend(32'({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}), 13);
      decode_pkg::imm_u: return {inst[31:12], 12'h000};
      default:
        return sign_extend(32'({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}), 21);
    endcase
  endfunction

  function automatic logic pending_in_pipe(input decode_pkg::reg_idx_t src);
    return (src != '0) && ((agex_wr_reg && agex_rd == src) || (mem_wr_reg && mem_rd == src) ||
                           (wb_wr_reg && wb_rd == src));
  endfunction

  function automatic decode_pkg::inst_t encode(input logic [6:0] opc, input logic [2:0] f3,
                                              input logic [6:0] f7);
    decode_pkg::inst_t inst;
    inst        = $urandom;  // other fields stay random
    inst[6:0]   = opc;
    inst[14:12] = f3;
    inst[31:25] = f7;
    return inst;
  endfunction

  task automatic predict();
    decode_pkg::iop_t       op;
    decode_pkg::inst_type_t t;
    decode_pkg::imm_type_t  k;
    logic                   use1;
    logic                   use2;
    op = lookup_op(fe_inst);
    classify(op, t, k);
    use1 = !(op inside {decode_pkg::op_invalid, decode_pkg::op_lui, decode_pkg::op_auipc,
                        decode_pkg::op_jal});
    use2 = (t == decode_pkg::type_r) || (t == decode_pkg::type_s);
    exp_stall = (use1 && pending_in_pipe(fe_inst[19:15])) ||
                (use2 && pending_in_pipe(fe_inst[24:20]));
    exp_next = '0;
    if (!exp_stall && !agex_br_taken && fe_inst != '0) begin
      exp_next.inst    = fe_inst;
      exp_next.pc      = fe_pc;
      exp_next.pcplus  = fe_pcplus;
      exp_next.op      = op;
      exp_next.typ     = t;
      exp_next.regval1 = ref_regs[fe_inst[19:15]];
      exp_next.regval2 = ref_regs[fe_inst[24:20]];
      exp_next.imm     = layout_imm(fe_inst, k);
      exp_next.rd      = fe_inst[11:7];
      exp_next.wr_reg  = (op != decode_pkg::op_invalid) && (op != decode_pkg::op_sw) &&
                         (k != decode_pkg::imm_b);
    end
    if (wb_wr_reg && wb_rd != '0) ref_regs[wb_rd] = wb_data;  // read sees it next cycle
  endtask

  task automatic drive(input decode_pkg::inst_t inst, input logic br, input logic [17:0] hz,
                       input logic [31:0] data);
    @(negedge clk);
    fe_inst       = inst;
    fe_pc         = $urandom & 32'hffff_fffc;
    fe_pcplus     = fe_pc + 32'd4;
    agex_br_taken = br;
    {agex_rd, agex_wr_reg, mem_rd, mem_wr_reg, wb_rd, wb_wr_reg} = hz;
    wb_data       = data;
    predict();
  endtask

  initial begin
    decode_pkg::inst_t    inst;
    decode_pkg::reg_idx_t r;
    void'($urandom(32'h87105487));
    reset         = 1'b1;
    fe_inst       = '0;
    fe_pc         = '0;
    fe_pcplus     = '0;
    agex_rd       = '0;
    agex_wr_reg   = 1'b0;
    mem_rd        = '0;
    mem_wr_reg    = 1'b0;
    wb_rd         = '0;
    wb_wr_reg     = 1'b0;
    wb_data       = '0;
    agex_br_taken = 1'b0;
    exp_next      = '0;
    exp_stall     = 1'b0;
    cycles        = 0;
    foreach (ref_regs[i]) ref_regs[i] = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // write through wb, then read back with an add while the pipe is quiet
    for (int n = 0; n < 40; n++) begin
      r = (n == 0) ? 5'd0 : 5'($urandom_range(0, 31));  // first write goes to x0
      drive('0, 1'b0, {12'd0, r, 1'b1}, $urandom);
      inst = encode(decode_pkg::opcode_op, 3'd0, decode_pkg::funct7_base);
      inst[19:15] = r;
      drive(inst, 1'b0, 18'd0, '0);
    end

    // every opcode, funct3 and funct7 choice, valid and invalid
    foreach (opcodes[o]) begin
      for (int f3 = 0; f3 < 8; f3++) begin
        foreach (f7s[s]) drive(encode(opcodes[o], 3'(f3), f7s[s]), 1'b0, 18'd0, '0);
      end
    end
    repeat (40) drive($urandom, 1'b0, 18'd0, '0);

    foreach (opcodes[o]) begin  // immediate bits fully random
      repeat (6) drive(encode(opcodes[o], 3'd0, 7'($urandom)), 1'b0, 18'd0, '0);
    end

    repeat (120) begin  // small register numbers so hazards hit often
      inst = encode(opcodes[$urandom_range(0, 8)], 3'($urandom), f7s[$urandom_range(0, 2)]);
      inst[19:15] = 5'($urandom_range(0, 3));
      inst[24:20] = 5'($urandom_range(0, 3));
      drive(inst, 1'b0, 18'($urandom) & near_mask, $urandom);
    end

    repeat (20) begin
      inst = encode(opcodes[$urandom_range(0, 8)], 3'd0, decode_pkg::funct7_base);
      drive(inst, 1'b1, 18'd0, '0);
      drive('0, 1'b0, 18'($urandom) & near_mask, $urandom);
    end

    drive('0, 1'b0, 18'd0, '0);
    repeat (2) @(posedge clk);
    @(negedge clk);
    $display("TEST OK");
    $finish;
  end

endmodule

/* files.f */
hdl/decode_pkg.sv
hdl/inst_decoder.sv
hdl/imm_gen.sv
hdl/reg_file.sv
hdl/hazard_unit.sv
hdl/decode_stage.sv
sim/decode_stage_tb.sv
